//--- source/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// --------------------
// Bus widths
// --------------------
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// --------------------
// Address map
// --------------------
`define SOC_ROM_BASE   32'h0000_1000
`define SOC_ROM_WORDS  16
`define SOC_ROM_SIZE   32'h0000_0040
`define SOC_RAM_BASE   32'h8000_0000
`define SOC_RAM_WORDS  256
`define SOC_RAM_SIZE   32'h0000_0400
`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_SIZE 32'h0000_0010

// CLINT register byte offsets
`define SOC_CLINT_MTIME_LO    4'h0
`define SOC_CLINT_MTIME_HI    4'h4
`define SOC_CLINT_MTIMECMP_LO 4'h8
`define SOC_CLINT_MTIMECMP_HI 4'hC

// Cycles the debug request stays blocked after reset
`define SOC_DEBUG_HOLD_CYCLES 500

`endif

//--- source/soc_pkg.sv
`include "soc_defs.svh"

package soc_pkg;

  // --------------------
  // Bus types
  // --------------------
  typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;
  typedef logic [`SOC_DATA_W-1:0] bus_data_t;

  // Word indices into the memories
  typedef logic [$clog2(`SOC_ROM_WORDS)-1:0] rom_index_t;
  typedef logic [$clog2(`SOC_RAM_WORDS)-1:0] ram_index_t;

  // mtime and mtimecmp span two bus words
  typedef logic [2*`SOC_DATA_W-1:0] clint_time_t;

  // Counter for the debug hold-off window
  typedef logic [$clog2(`SOC_DEBUG_HOLD_CYCLES+1)-1:0] hold_cnt_t;

  // --------------------
  // Decoded destination
  // --------------------
  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_RAM,
    TGT_CLINT,
    TGT_NONE
  } target_e;

endpackage

//--- source/bus_router.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module bus_router import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       ndmreset_n,
  // Request channel from the master
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  bus_addr_t  req_addr_i,
  input  logic       req_we_i,
  input  bus_data_t  req_wdata_i,
  // Response channel back to the master
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output bus_data_t  rsp_rdata_o,
  output logic       rsp_err_o,
  // Target side
  output logic       rom_sel_o,
  output logic       ram_sel_o,
  output logic       clint_sel_o,
  output ram_index_t tgt_index_o,
  output logic       tgt_we_o,
  output bus_data_t  tgt_wdata_o,
  input  bus_data_t  rom_rdata_i,
  input  bus_data_t  ram_rdata_i,
  input  bus_data_t  clint_rdata_i
);

  target_e   tgt;
  logic      legal;
  logic      req_fire;
  bus_data_t rdata_mux;

  logic      rsp_valid_q;
  bus_data_t rsp_rdata_q;
  logic      rsp_err_q;

  // Base-relative compare stays safe against wrap at the top of the map
  function automatic logic in_window(bus_addr_t addr, bus_addr_t base, bus_addr_t size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

  // --------------------
  // Address decode
  // --------------------
  always_comb begin
    if (in_window(req_addr_i, `SOC_ROM_BASE, `SOC_ROM_SIZE)) begin
      tgt = TGT_ROM;
    end else if (in_window(req_addr_i, `SOC_RAM_BASE, `SOC_RAM_SIZE)) begin
      tgt = TGT_RAM;
    end else if (in_window(req_addr_i, `SOC_CLINT_BASE, `SOC_CLINT_SIZE)) begin
      tgt = TGT_CLINT;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // ROM is read-only
  assign legal = (tgt != TGT_NONE) && !(tgt == TGT_ROM && req_we_i);

  // Single slot accepts when empty or when it drains this cycle
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  // --------------------
  // Target strobes
  // --------------------
  assign rom_sel_o   = req_fire && legal && (tgt == TGT_ROM);
  assign ram_sel_o   = req_fire && legal && (tgt == TGT_RAM);
  assign clint_sel_o = req_fire && legal && (tgt == TGT_CLINT);

  // Windows are aligned, so the low address bits are the word index
  assign tgt_index_o = req_addr_i[2 +: $bits(ram_index_t)];
  assign tgt_we_o    = req_we_i;
  assign tgt_wdata_o = req_wdata_i;

  // Writes and errors answer with zero data
  always_comb begin
    rdata_mux = '0;
    if (legal && !req_we_i) begin
      case (tgt)
        TGT_ROM:   rdata_mux = rom_rdata_i;
        TGT_RAM:   rdata_mux = ram_rdata_i;
        TGT_CLINT: rdata_mux = clint_rdata_i;
        default:   rdata_mux = '0;
      endcase
    end
  end

  // --------------------
  // Response slot
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_rdata_q <= rdata_mux;
      rsp_err_q   <= !legal;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;

endmodule

//--- source/boot_rom.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module boot_rom import soc_pkg::*; (
  input  logic       rom_sel_i,
  input  rom_index_t rom_index_i,
  output bus_data_t  rom_rdata_o
);

  // --------------------
  // Boot program
  // --------------------
  localparam bus_data_t ROM_TABLE [`SOC_ROM_WORDS] = '{
    32'h0000_0297,  // auipc t0, 0
    32'h0202_8293,
    32'h0002_8067,
    32'hf140_2573,  // hart id into a0
    32'h0000_0597,
    32'h0305_8593,
    32'h8000_02b7,  // jump target is the scratchpad
    32'h0002_8067,
    32'h1050_0073,  // wfi
    32'hffdf_f06f,
    32'h0000_0013,
    32'h0000_0013,
    32'hd00d_feed,
    32'h0000_0040,
    32'h0000_1000,
    32'hc0de_b007
  };

  // Idle output when not selected
  assign rom_rdata_o = rom_sel_i ? ROM_TABLE[rom_index_i] : '0;

endmodule

//--- source/scratch_ram.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module scratch_ram import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       ram_sel_i,
  input  logic       ram_we_i,
  input  ram_index_t ram_index_i,
  input  bus_data_t  ram_wdata_i,
  output bus_data_t  ram_rdata_o
);

  // --------------------
  // Storage
  // --------------------
  bus_data_t mem [`SOC_RAM_WORDS];

  always_ff @(posedge clk_i) begin
    if (ram_sel_i && ram_we_i) begin
      mem[ram_index_i] <= ram_wdata_i;
    end
  end

  // Read path feeds the router in the same cycle
  assign ram_rdata_o = ram_sel_i ? mem[ram_index_i] : '0;

endmodule

//--- source/clint_timer.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module clint_timer import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       ndmreset_n,
  input  logic       rtc_i,
  input  logic       clint_sel_i,
  input  logic       clint_we_i,
  input  ram_index_t clint_index_i,
  input  bus_data_t  clint_wdata_i,
  output bus_data_t  clint_rdata_o,
  output logic       timer_irq_o
);

  logic [1:0]  rtc_sync_q;
  logic        rtc_prev_q;
  logic        rtc_rise;
  logic        rtc_div_q;
  logic        tick;
  logic [3:0]  reg_off;
  logic        wr_en;

  clint_time_t mtime_q;
  clint_time_t mtimecmp_q;
  logic        timer_irq_q;

  // --------------------
  // RTC input
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_div_q <= ~rtc_div_q;
      end
    end
  end

  assign rtc_rise = rtc_sync_q[1] && !rtc_prev_q;
  // Divided clock goes high on this rtc edge
  assign tick     = rtc_rise && !rtc_div_q;

  // Register select from the two low word-index bits
  assign reg_off = {clint_index_i[1:0], 2'b00};
  assign wr_en   = clint_sel_i && clint_we_i;

  // --------------------
  // Timer registers
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      // A bus write wins over the tick in the same cycle
      if (wr_en && reg_off == `SOC_CLINT_MTIME_LO) begin
        mtime_q[31:0] <= clint_wdata_i;
      end else if (wr_en && reg_off == `SOC_CLINT_MTIME_HI) begin
        mtime_q[63:32] <= clint_wdata_i;
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && reg_off == `SOC_CLINT_MTIMECMP_LO) begin
        mtimecmp_q[31:0] <= clint_wdata_i;
      end
      if (wr_en && reg_off == `SOC_CLINT_MTIMECMP_HI) begin
        mtimecmp_q[63:32] <= clint_wdata_i;
      end
    end
  end

  always_comb begin
    clint_rdata_o = '0;
    if (clint_sel_i) begin
      case (reg_off)
        `SOC_CLINT_MTIME_LO:    clint_rdata_o = mtime_q[31:0];
        `SOC_CLINT_MTIME_HI:    clint_rdata_o = mtime_q[63:32];
        `SOC_CLINT_MTIMECMP_LO: clint_rdata_o = mtimecmp_q[31:0];
        default:                clint_rdata_o = mtimecmp_q[63:32];
      endcase
    end
  end

  // Interrupt one cycle behind the compare
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      timer_irq_q <= 1'b0;
    end else begin
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign timer_irq_o = timer_irq_q;

endmodule

//--- source/debug_hold.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module debug_hold import soc_pkg::*; (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  // Gives the boot code time to run before a halt request lands
  hold_cnt_t hold_cnt_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      hold_cnt_q <= hold_cnt_t'(`SOC_DEBUG_HOLD_CYCLES);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // Pass-through once the window has expired
  assign debug_req_o = (hold_cnt_q == '0) && debug_req_i;

endmodule

//--- source/soc_subsystem.sv
`timescale 1ns/10ps

module soc_subsystem import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      ndmreset_n,
  input  logic      rtc_i,
  // Request channel
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  bus_addr_t req_addr_i,
  input  logic      req_we_i,
  input  bus_data_t req_wdata_i,
  // Response channel
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output bus_data_t rsp_rdata_o,
  output logic      rsp_err_o,
  // Core side
  input  logic      debug_req_i,
  output logic      debug_req_o,
  output logic      timer_irq_o
);

  logic       rom_sel;
  logic       ram_sel;
  logic       clint_sel;
  ram_index_t tgt_index;
  logic       tgt_we;
  bus_data_t  tgt_wdata;
  bus_data_t  rom_rdata;
  bus_data_t  ram_rdata;
  bus_data_t  clint_rdata;

  // --------------------
  // Bus fabric
  // --------------------
  bus_router i_bus_router (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_valid_i   ( req_valid_i ),
    .req_ready_o   ( req_ready_o ),
    .req_addr_i    ( req_addr_i  ),
    .req_we_i      ( req_we_i    ),
    .req_wdata_i   ( req_wdata_i ),
    .rsp_valid_o   ( rsp_valid_o ),
    .rsp_ready_i   ( rsp_ready_i ),
    .rsp_rdata_o   ( rsp_rdata_o ),
    .rsp_err_o     ( rsp_err_o   ),
    .rom_sel_o     ( rom_sel     ),
    .ram_sel_o     ( ram_sel     ),
    .clint_sel_o   ( clint_sel   ),
    .tgt_index_o   ( tgt_index   ),
    .tgt_we_o      ( tgt_we      ),
    .tgt_wdata_o   ( tgt_wdata   ),
    .rom_rdata_i   ( rom_rdata   ),
    .ram_rdata_i   ( ram_rdata   ),
    .clint_rdata_i ( clint_rdata )
  );

  // --------------------
  // Slaves
  // --------------------
  boot_rom i_boot_rom (
    .rom_sel_i   ( rom_sel                         ),
    .rom_index_i ( tgt_index[$bits(rom_index_t)-1:0] ),
    .rom_rdata_o ( rom_rdata                       )
  );

  scratch_ram i_scratch_ram (
    .clk_i       ( clk_i     ),
    .ram_sel_i   ( ram_sel   ),
    .ram_we_i    ( tgt_we    ),
    .ram_index_i ( tgt_index ),
    .ram_wdata_i ( tgt_wdata ),
    .ram_rdata_o ( ram_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .rtc_i         ( rtc_i       ),
    .clint_sel_i   ( clint_sel   ),
    .clint_we_i    ( tgt_we      ),
    .clint_index_i ( tgt_index   ),
    .clint_wdata_i ( tgt_wdata   ),
    .clint_rdata_o ( clint_rdata ),
    .timer_irq_o   ( timer_irq_o )
  );

  // Debug request gate toward the core
  debug_hold i_debug_hold (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic ndmreset_n
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lands a little after the edge as the other stimulus does
  initial begin
    ndmreset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #10;
    ndmreset_n = 1'b1;
  end

endmodule

//--- tb/tb_soc_subsystem.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module tb_soc_subsystem;

  localparam int WAIT_LIMIT = 50;
  localparam int IRQ_LIMIT  = 400;

  logic                   clk;
  logic                   ndmreset_n;
  logic                   rtc_i;
  logic                   req_valid_i;
  logic                   req_ready_o;
  logic [`SOC_ADDR_W-1:0] req_addr_i;
  logic                   req_we_i;
  logic [`SOC_DATA_W-1:0] req_wdata_i;
  logic                   rsp_valid_o;
  logic                   rsp_ready_i;
  logic [`SOC_DATA_W-1:0] rsp_rdata_o;
  logic                   rsp_err_o;
  logic                   debug_req_i;
  logic                   debug_req_o;
  logic                   timer_irq_o;

  // Operations read from the data file
  logic        op_we_q[$];
  logic [31:0] op_addr_q[$];
  logic [31:0] op_wdata_q[$];
  logic [31:0] op_rdata_q[$];
  logic [31:0] op_err_q[$];

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) i_clock_gen (
    .clk_o      ( clk        ),
    .ndmreset_n ( ndmreset_n )
  );

  soc_subsystem dut (
    .clk_i       ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_addr_i  ( req_addr_i  ),
    .req_we_i    ( req_we_i    ),
    .req_wdata_i ( req_wdata_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o )
  );

  // Slow real-time clock with 14 clk cycles per period
  initial begin
    rtc_i = 1'b0;
    forever begin
      repeat (7) @(posedge clk);
      #10;
      rtc_i = ~rtc_i;
    end
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_at_start);
    end
  endtask

  function automatic string group_name(input logic [31:0] addr);
    if (addr >= `SOC_ROM_BASE && (addr - `SOC_ROM_BASE) < `SOC_ROM_SIZE) begin
      return "boot ROM";
    end
    if (addr >= `SOC_RAM_BASE && (addr - `SOC_RAM_BASE) < `SOC_RAM_SIZE) begin
      return "scratchpad with back-pressure";
    end
    return "unmapped addresses";
  endfunction

  task automatic load_ops();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] e;
    fd = $fopen("tb/bus_input.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open the stimulus file tb/bus_input.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c %h %h %h %h", op, a, w, r, e);
        if (n == 5) begin
          op_we_q.push_back(op == "W");
          op_addr_q.push_back(a);
          op_wdata_q.push_back(w);
          op_rdata_q.push_back(r);
          op_err_q.push_back(e);
        end
      end
    end
    $fclose(fd);
  endtask

  // One transfer with rsp_ready_i held high
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output bit ok);
    int guard;
    ok    = 1'b0;
    rdata = '0;
    err   = 1'b0;
    @(posedge clk);
    #10;
    rsp_ready_i = 1'b1;
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    guard = 0;
    @(negedge clk);
    while (!req_ready_o && guard < WAIT_LIMIT) begin
      guard++;
      @(negedge clk);
    end
    @(posedge clk);
    #10;
    req_valid_i = 1'b0;
    if (guard >= WAIT_LIMIT) begin
      $display("ERROR: timeout waiting for req_ready_o at address %h", addr);
      errors++;
      return;
    end
    guard = 0;
    @(negedge clk);
    while (!rsp_valid_o && guard < WAIT_LIMIT) begin
      guard++;
      @(negedge clk);
    end
    if (!rsp_valid_o) begin
      $display("ERROR: timeout waiting for a response from address %h", addr);
      errors++;
      return;
    end
    rdata = rsp_rdata_o;
    err   = rsp_err_o;
    ok    = 1'b1;
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic check_reset_state();
    int errs_at_start;
    int guard;
    errs_at_start = errors;
    guard = 0;
    @(negedge clk);
    while (!ndmreset_n && guard < 20) begin
      check_value("rsp_valid_o", 32'(0), 32'(rsp_valid_o));
      check_value("timer_irq_o", 32'(0), 32'(timer_irq_o));
      check_value("debug_req_o", 32'(0), 32'(debug_req_o));
      check_value("req_ready_o", 32'(1), 32'(req_ready_o));
      guard++;
      @(negedge clk);
    end
    if (!ndmreset_n) begin
      $display("ERROR: timeout waiting for ndmreset_n to be released");
      errors++;
    end
    // First cycle out of reset
    check_value("rsp_valid_o", 32'(0), 32'(rsp_valid_o));
    check_value("timer_irq_o", 32'(0), 32'(timer_irq_o));
    check_value("debug_req_o", 32'(0), 32'(debug_req_o));
    check_value("req_ready_o", 32'(1), 32'(req_ready_o));
    report_test("reset state", errs_at_start);
  endtask

  task automatic test_debug_hold();
    int errs_at_start;
    int k;
    errs_at_start = errors;
    for (k = 1; k <= `SOC_DEBUG_HOLD_CYCLES + 8; k++) begin
      @(negedge clk);
      check_value("debug_req_o", 32'(k >= `SOC_DEBUG_HOLD_CYCLES), 32'(debug_req_o));
    end
    report_test("debug hold-off", errs_at_start);
  endtask

  // Streams the file operations back to back under random rsp_ready_i
  task automatic run_stream();
    int   issue_idx;
    int   done_idx;
    int   stall;
    int   k;
    int   grp_errs;
    int   exp_q[$];
    logic fired;
    issue_idx = 0;
    done_idx  = 0;
    stall     = 0;
    fired     = 1'b0;
    grp_errs  = errors;
    while (done_idx < op_addr_q.size() && stall < WAIT_LIMIT) begin
      @(posedge clk);
      #10;
      rsp_ready_i = ($urandom % 100) >= 30;
      req_valid_i = issue_idx < op_addr_q.size();
      if (req_valid_i) begin
        req_we_i    = op_we_q[issue_idx];
        req_addr_i  = op_addr_q[issue_idx];
        req_wdata_i = op_wdata_q[issue_idx];
      end
      @(negedge clk);
      stall++;
      if (fired) begin
        check_value("rsp_valid_o", 32'(1), 32'(rsp_valid_o));
      end
      fired = 1'b0;
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: response arrived with no request outstanding");
          errors++;
        end else begin
          k = exp_q.pop_front();
          check_value("rsp_rdata_o", op_rdata_q[k], rsp_rdata_o);
          check_value("rsp_err_o", op_err_q[k], 32'(rsp_err_o));
          done_idx++;
          stall = 0;
          if (k == op_addr_q.size() - 1 ||
              group_name(op_addr_q[k + 1]) != group_name(op_addr_q[k])) begin
            report_test(group_name(op_addr_q[k]), grp_errs);
            grp_errs = errors;
          end
        end
      end
      if (req_valid_i && req_ready_o) begin
        exp_q.push_back(issue_idx);
        issue_idx++;
        fired = 1'b1;
        stall = 0;
      end
    end
    @(posedge clk);
    #10;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    if (done_idx < op_addr_q.size()) begin
      $display("ERROR: timeout in the request stream after %0d responses", done_idx);
      errors++;
    end
  endtask

  task automatic test_timer();
    int          errs_at_start;
    int          guard;
    logic [31:0] first;
    logic [31:0] prev;
    logic [31:0] cur;
    logic [31:0] rd;
    logic        err;
    bit          ok;
    errs_at_start = errors;
    bus_access(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIME_LO, '0, first, err, ok);
    prev  = first;
    cur   = first;
    guard = 0;
    while (ok && cur == first && guard < 60) begin
      repeat (4) @(posedge clk);
      bus_access(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIME_LO, '0, cur, err, ok);
      assert (cur >= prev) else begin
        $display("FAILED mtime_lo went backwards from %h to %h", prev, cur);
        errors++;
      end
      prev = cur;
      guard++;
    end
    if (cur == first) begin
      $display("ERROR: mtime_lo never advanced");
      errors++;
    end
    // Compare point a few ticks ahead
    bus_access(1'b1, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_LO, cur + 32'd4, rd, err, ok);
    check_value("rsp_err_o", 32'(0), 32'(err));
    check_value("rsp_rdata_o", 32'(0), rd);
    bus_access(1'b1, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_HI, 32'h0, rd, err, ok);
    check_value("rsp_err_o", 32'(0), 32'(err));
    check_value("rsp_rdata_o", 32'(0), rd);
    guard = 0;
    while (!timer_irq_o && guard < IRQ_LIMIT) begin
      guard++;
      @(negedge clk);
    end
    if (!timer_irq_o) begin
      $display("ERROR: timeout waiting for timer_irq_o to rise");
      errors++;
    end
    bus_access(1'b1, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_HI, 32'hffff_ffff, rd, err, ok);
    bus_access(1'b1, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_LO, 32'hffff_ffff, rd, err, ok);
    guard = 0;
    while (timer_irq_o && guard < WAIT_LIMIT) begin
      guard++;
      @(negedge clk);
    end
    if (timer_irq_o) begin
      $display("ERROR: timeout waiting for timer_irq_o to drop");
      errors++;
    end
    report_test("timer", errs_at_start);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(49));
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_we_i    = 1'b0;
    req_wdata_i = '0;
    rsp_ready_i = 1'b0;
    debug_req_i = 1'b1;
    load_ops();
    check_reset_state();
    fork
      test_debug_hold();
      begin
        run_stream();
        test_timer();
      end
    join
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+source
source/soc_pkg.sv
source/bus_router.sv
source/boot_rom.sv
source/scratch_ram.sv
source/clint_timer.sv
source/debug_hold.sv
source/soc_subsystem.sv
tb/tb_clock_gen.sv
tb/tb_soc_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result goes to sim.log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f \
  --top-module tb_soc_subsystem \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0

//--- tb/bus_input.txt
# op addr wdata exp_rdata exp_err  (op is R or W, the rest in hex)
# Boot ROM, then the scratchpad, then unmapped addresses
R 00001000 00000000 00000297 0
R 00001004 00000000 02028293 0
R 00001008 00000000 00028067 0
R 0000100c 00000000 f1402573 0
R 00001010 00000000 00000597 0
R 00001014 00000000 03058593 0
R 00001018 00000000 800002b7 0
R 0000101c 00000000 00028067 0
R 00001020 00000000 10500073 0
R 00001024 00000000 ffdff06f 0
R 00001028 00000000 00000013 0
R 0000102c 00000000 00000013 0
R 00001030 00000000 d00dfeed 0
R 00001034 00000000 00000040 0
R 00001038 00000000 00001000 0
R 0000103c 00000000 c0deb007 0
W 0000100c deadbeef 00000000 1
R 0000100c 00000000 f1402573 0
W 80000000 11223344 00000000 0
W 80000004 a5a5a5a5 00000000 0
W 800003fc 0badf00d 00000000 0
R 80000000 00000000 11223344 0
R 80000004 00000000 a5a5a5a5 0
R 800003fc 00000000 0badf00d 0
R 00002000 00000000 00000000 1
W 02000010 12345678 00000000 1
R 80000400 00000000 00000000 1
